//--- all.f
common/rv_isa_pkg.sv
common/pipe_pkg.sv
hw/stage_reg.sv
execute/ex_stage.sv
memory/me_stage.sv
hw/ex_me_top.sv
+incdir+tb
tb/tb_ex_me.sv

//--- common/pipe_pkg.sv
package pipe_pkg;

    localparam int DMEM_WORDS = 256;                 // doublewords in the data ram.
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // word index bits, taken above the offset.

    // payload of the ex/me slot. Everything the memory stage and the redirect path need
    // travels here, so the slot register does not have to know any of the fields.
    typedef struct packed {
        logic                                  valid;        // cleared for bubbles and squashes.
        logic [rv_isa_pkg::XLEN-1:0]           pc;           // needed for the link value.
        logic [rv_isa_pkg::XLEN-1:0]           alu_res;      // result or memory address.
        logic [rv_isa_pkg::XLEN-1:0]           store_data;   // raw rs2, lanes placed in me.
        logic [rv_isa_pkg::XLEN_BYTES-1:0]     byte_mask;    // byte lanes a store touches.
        logic                                  mem_read;
        logic                                  mem_write;
        rv_isa_pkg::mem_size_e                 size;
        logic                                  sext;         // sign extend a load result.
        rv_isa_pkg::wb_sel_e                   wb_sel;
        logic                                  write_rd;
        logic [4:0]                            rd;
        logic                                  redirect;     // jump or taken branch.
        logic [rv_isa_pkg::XLEN-1:0]           redirect_pc;  // where fetch must go next.
    } ex_me_t;

    // payload of the me/wb slot, already reduced to what the register file needs.
    typedef struct packed {
        logic                                  valid;
        logic                                  write_rd;     // includes valid and rd != 0.
        logic [4:0]                            rd;
        logic [rv_isa_pkg::XLEN-1:0]           wb_data;
    } me_wb_t;

    // handy when the testbench or a later stage wants to size things off the ram.
    localparam int DMEM_BYTES = DMEM_WORDS * rv_isa_pkg::XLEN_BYTES;

    // byte address bits that select a word, the rest of the address wraps in the ram.
    localparam int DMEM_ADDR_HI = DMEM_AW + 2;

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN       = 64;            // integer register width for rv64i.
    localparam int XLEN_BYTES = XLEN / 8;      // byte lanes in one register or doubleword.
    localparam int SHAMT_W    = $clog2(XLEN);  // shifts only look at this many low bits of b.

    // alu operation as chosen by decode. The encoding is internal and does not follow
    // funct3, so decode is free to map both op and op-imm forms onto the same value.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,   // also forms load and store addresses.
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,   // signed compare, result is 0 or 1.
        ALU_SLTU = 4'd4,   // unsigned compare, result is 0 or 1.
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,   // keeps the sign of operand a.
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_LUI  = 4'd10   // passes operand b through, decode puts the upper immediate there.
    } alu_op_e;

    // branch condition, encoded exactly as the funct3 field of the branch instruction.
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    // access size for loads and stores, matching the low two bits of funct3.
    typedef enum logic [1:0] {
        MEM_B = 2'b00,  // one byte.
        MEM_H = 2'b01,  // two bytes.
        MEM_W = 2'b10,  // four bytes.
        MEM_D = 2'b11   // eight bytes.
    } mem_size_e;

    // source of the value written back to rd.
    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_MEM  = 2'b01,
        WB_LINK = 2'b10   // pc + 4 for jal and jalr.
    } wb_sel_e;

endpackage

//--- execute/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                        valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] imm_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rs1_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rs2_i,
    input  rv_isa_pkg::alu_op_e         alu_op_i,
    input  logic                        src_a_pc_i,   // operand a is pc instead of rs1.
    input  logic                        src_b_imm_i,  // operand b is imm instead of rs2.
    input  logic                        branch_i,
    input  rv_isa_pkg::br_cond_e        br_cond_i,
    input  logic                        jal_i,
    input  logic                        jalr_i,
    input  logic                        mem_read_i,
    input  logic                        mem_write_i,
    input  rv_isa_pkg::mem_size_e       size_i,
    input  logic                        sext_i,
    input  rv_isa_pkg::wb_sel_e         wb_sel_i,
    input  logic                        write_rd_i,
    input  logic [4:0]                  rd_i,
    input  logic                        squash_i,     // the slot ahead is redirecting.
    output pipe_pkg::ex_me_t            ex_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [SHAMT_W-1:0]    shamt;
    logic [XLEN-1:0]       alu_res;
    logic                  br_taken;
    logic                  live;         // valid and not on the wrong path.
    logic [XLEN-1:0]       jalr_sum;
    logic [XLEN-1:0]       target;
    logic [2:0]            mem_off;
    logic [XLEN_BYTES-1:0] size_mask;
    logic [2:0]            align_mask;

    assign op_a  = src_a_pc_i ? pc_i : rs1_i;
    assign op_b  = src_b_imm_i ? imm_i : rs2_i;
    assign shamt = op_b[SHAMT_W-1:0];     // rv64 shifts use six bits of b.

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, (op_a < op_b)};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);  // fills with the sign.
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_LUI:  alu_res = op_b;                // the immediate is already shifted.
            default:  alu_res = '0;
        endcase
    end

    // branch compare always works on the register values, never on the operand muxes.
    always_comb begin
        case (br_cond_i)
            BR_EQ:   br_taken = (rs1_i == rs2_i);
            BR_NE:   br_taken = (rs1_i != rs2_i);
            BR_LT:   br_taken = ($signed(rs1_i) < $signed(rs2_i));
            BR_GE:   br_taken = ($signed(rs1_i) >= $signed(rs2_i));
            BR_LTU:  br_taken = (rs1_i < rs2_i);
            BR_GEU:  br_taken = (rs1_i >= rs2_i);
            default: br_taken = 1'b0;               // reserved funct3 never branches.
        endcase
    end

    assign live     = valid_i && !squash_i;
    assign jalr_sum = rs1_i + imm_i;
    assign target   = jalr_i ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;  // jalr drops bit 0.

    // the access starts at the low address bits and covers the size in bytes.
    assign mem_off = alu_res[2:0];

    always_comb begin
        case (size_i)
            MEM_B:   size_mask = 8'h01;
            MEM_H:   size_mask = 8'h03;
            MEM_W:   size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
        case (size_i)
            MEM_B:   align_mask = 3'b000;           // any byte address is fine.
            MEM_H:   align_mask = 3'b001;
            MEM_W:   align_mask = 3'b011;
            default: align_mask = 3'b111;
        endcase
        if (valid_i) begin
            a_jump_onehot: assert final (!(jal_i && jalr_i))
                else $error("ex_stage: jal and jalr both set.");
        end
        if (valid_i && (mem_read_i || mem_write_i)) begin
            a_aligned: assert final ((mem_off & align_mask) == 3'b000)
                else $error("ex_stage: misaligned access at %h.", alu_res);
        end
    end

    assign ex_o.valid       = live;
    assign ex_o.pc          = pc_i;
    assign ex_o.alu_res     = alu_res;
    assign ex_o.store_data  = rs2_i;              // lanes are placed in the memory stage.
    assign ex_o.byte_mask   = mem_write_i ? (size_mask << mem_off) : '0;
    assign ex_o.mem_read    = mem_read_i;
    assign ex_o.mem_write   = mem_write_i && !squash_i;  // a squashed store must not land.
    assign ex_o.size        = size_i;
    assign ex_o.sext        = sext_i;
    assign ex_o.wb_sel      = wb_sel_i;
    assign ex_o.write_rd    = write_rd_i && !squash_i;
    assign ex_o.rd          = rd_i;
    assign ex_o.redirect    = live && (jal_i || jalr_i || (branch_i && br_taken));
    assign ex_o.redirect_pc = target;

endmodule

//--- hw/ex_me_top.sv
`timescale 1ns/1ps

module ex_me_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] imm_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rs1_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rs2_i,
    input  rv_isa_pkg::alu_op_e         alu_op_i,
    input  logic                        src_a_pc_i,
    input  logic                        src_b_imm_i,
    input  logic                        branch_i,
    input  rv_isa_pkg::br_cond_e        br_cond_i,
    input  logic                        jal_i,
    input  logic                        jalr_i,
    input  logic                        mem_read_i,
    input  logic                        mem_write_i,
    input  rv_isa_pkg::mem_size_e       size_i,
    input  logic                        sext_i,
    input  rv_isa_pkg::wb_sel_e         wb_sel_i,
    input  logic                        write_rd_i,
    input  logic [4:0]                  rd_i,
    input  logic                        stall_i,      // bus wait, freezes both slots.
    input  logic                        bubble_i,     // empties the ex/me slot.
    input  logic                        flush_i,      // same effect as bubble on this half.
    output logic                        wb_en_o,
    output logic [4:0]                  wb_rd_o,
    output logic [rv_isa_pkg::XLEN-1:0] wb_data_o,
    output logic                        redirect_o,
    output logic [rv_isa_pkg::XLEN-1:0] redirect_pc_o
);
    import pipe_pkg::*;

    ex_me_t ex_d;   // execute result, before the slot.
    ex_me_t ex_q;   // the instruction now in memory.
    me_wb_t wb_d;
    me_wb_t wb_q;   // the instruction now in writeback.

    ex_stage u_ex (
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .imm_i       (imm_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .alu_op_i    (alu_op_i),
        .src_a_pc_i  (src_a_pc_i),
        .src_b_imm_i (src_b_imm_i),
        .branch_i    (branch_i),
        .br_cond_i   (br_cond_i),
        .jal_i       (jal_i),
        .jalr_i      (jalr_i),
        .mem_read_i  (mem_read_i),
        .mem_write_i (mem_write_i),
        .size_i      (size_i),
        .sext_i      (sext_i),
        .wb_sel_i    (wb_sel_i),
        .write_rd_i  (write_rd_i),
        .rd_i        (rd_i),
        .squash_i    (ex_q.redirect),  // the one behind a redirect is on the wrong path.
        .ex_o        (ex_d)
    );

    stage_reg #(.payload_t(ex_me_t)) u_ex_me (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .clear_i (flush_i || bubble_i),
        .d_i     (ex_d),
        .q_o     (ex_q)
    );

    me_stage u_me (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .ex_i    (ex_q),
        .wb_o    (wb_d)
    );

    stage_reg #(.payload_t(me_wb_t)) u_me_wb (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .clear_i (1'b0),               // nothing upstream ever cancels a finished access.
        .d_i     (wb_d),
        .q_o     (wb_q)
    );

    assign wb_en_o       = wb_q.write_rd;
    assign wb_rd_o       = wb_q.rd;
    assign wb_data_o     = wb_q.wb_data;
    assign redirect_o    = ex_q.redirect;     // seen one edge after execute.
    assign redirect_pc_o = ex_q.redirect_pc;

endmodule

//--- hw/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic  // the struct carried by this slot.
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     stall_i,         // hold the slot, wins over clear.
    input  logic     clear_i,         // bubble or flush, loads an empty slot.
    input  payload_t d_i,
    output payload_t q_o
);

    // one slot of the pipeline. The whole payload is cleared so that a bubble carries no
    // stale valid, write or redirect bits forward.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            q_o <= '0;                // the slot is empty after reset.
        end else if (!stall_i) begin
            if (clear_i) begin
                q_o <= '0;            // the instruction that would enter is dropped.
            end else begin
                q_o <= d_i;           // normal advance.
            end
        end
        // with stall high the slot keeps its contents.
    end

    // a clear that was not stalled leaves an empty slot on the next cycle.
    a_clear_empties: assert property (
        @(posedge clk) disable iff (reset_i)
        (clear_i && !stall_i) |=> (q_o == '0)
    ) else $error("stage_reg: slot not empty after an unstalled clear.");

endmodule

//--- memory/me_stage.sv
`timescale 1ns/1ps

module me_stage (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             stall_i,   // a stalled store waits in its slot.
    input  pipe_pkg::ex_me_t ex_i,
    output pipe_pkg::me_wb_t wb_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0]    dmem [DMEM_WORDS];  // data ram, one doubleword per entry.
    logic [DMEM_AW-1:0] word_idx;
    logic [2:0]         byte_off;
    logic [5:0]         bit_off;
    logic               mem_we;
    logic [XLEN-1:0]    wr_word;
    logic [XLEN-1:0]    rd_word;
    logic [XLEN-1:0]    rd_shift;
    logic [XLEN-1:0]    load_val;
    logic [XLEN-1:0]    link_pc;
    logic [XLEN-1:0]    wb_data;

    // bits above the ram size are ignored, so the address space wraps.
    assign word_idx = ex_i.alu_res[DMEM_ADDR_HI:3];
    assign byte_off = ex_i.alu_res[2:0];
    assign bit_off  = {byte_off, 3'b000};   // byte offset as a bit shift.

    // a store lands once, on the edge where its slot actually moves on.
    assign mem_we  = ex_i.valid && ex_i.mem_write && !stall_i && !reset_i;
    assign wr_word = ex_i.store_data << bit_off;  // put the low bytes of rs2 on their lanes.

    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int b = 0; b < XLEN_BYTES; b++) begin
                if (ex_i.byte_mask[b]) begin
                    dmem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];  // only masked lanes.
                end
            end
        end
    end

    // the read is combinational, so a load sees a store from the edge just before.
    assign rd_word  = dmem[word_idx];
    assign rd_shift = rd_word >> bit_off;   // the addressed byte ends up in lane 0.

    always_comb begin
        case (ex_i.size)
            MEM_B: begin
                if (ex_i.sext) begin
                    load_val = {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
                end else begin
                    load_val = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
                end
            end
            MEM_H: begin
                if (ex_i.sext) begin
                    load_val = {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
                end else begin
                    load_val = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
                end
            end
            MEM_W: begin
                if (ex_i.sext) begin
                    load_val = {{(XLEN-32){rd_shift[31]}}, rd_shift[31:0]};
                end else begin
                    load_val = {{(XLEN-32){1'b0}}, rd_shift[31:0]};
                end
            end
            default: begin
                load_val = rd_shift;        // a doubleword is aligned, no extension needed.
            end
        endcase
    end

    assign link_pc = ex_i.pc + XLEN'(4);    // return address for jal and jalr.

    always_comb begin
        case (ex_i.wb_sel)
            WB_MEM:  wb_data = load_val;
            WB_LINK: wb_data = link_pc;
            default: wb_data = ex_i.alu_res;
        endcase
    end

    assign wb_o.valid    = ex_i.valid;
    assign wb_o.write_rd = ex_i.valid && ex_i.write_rd && (ex_i.rd != 5'd0);  // x0 stays zero.
    assign wb_o.rd       = ex_i.rd;
    assign wb_o.wb_data  = wb_data;

    // decode never marks one instruction as both load and store.
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (reset_i)
        ex_i.valid |-> !(ex_i.mem_read && ex_i.mem_write)
    ) else $error("me_stage: load and store set together.");

endmodule

//--- tb/ex_me_tests.svh
`ifndef EX_ME_TESTS_SVH
`define EX_ME_TESTS_SVH

task automatic zero_inputs();
    valid_i <= 1'b0;
    pc_i <= '0;
    imm_i <= '0;
    rs1_i <= '0;
    rs2_i <= '0;
    alu_op_i <= ALU_ADD;
    src_a_pc_i <= 1'b0;
    src_b_imm_i <= 1'b0;
    branch_i <= 1'b0;
    br_cond_i <= BR_EQ;
    jal_i <= 1'b0;
    jalr_i <= 1'b0;
    mem_read_i <= 1'b0;
    mem_write_i <= 1'b0;
    size_i <= MEM_B;
    sext_i <= 1'b0;
    wb_sel_i <= WB_ALU;
    write_rd_i <= 1'b0;
    rd_i <= '0;
    stall_i <= 1'b0;
    bubble_i <= 1'b0;
    flush_i <= 1'b0;
endtask

task automatic idle();
    @(posedge clk);
    zero_inputs();
endtask

task automatic issue_alu(alu_op_e op, logic a_pc, logic b_imm, logic [63:0] pc,
                         logic [63:0] rs1, logic [63:0] rs2, logic [63:0] imm, logic [4:0] rd);
    idle();                                    // later assignments override the zeros.
    valid_i <= 1'b1;
    alu_op_i <= op;
    src_a_pc_i <= a_pc;
    src_b_imm_i <= b_imm;
    pc_i <= pc;
    rs1_i <= rs1;
    rs2_i <= rs2;
    imm_i <= imm;
    write_rd_i <= 1'b1;
    rd_i <= rd;
endtask

task automatic issue_mem(logic store, int size, logic sext, logic [63:0] addr,
                         logic [63:0] data);
    idle();
    valid_i <= 1'b1;
    rs1_i <= addr;
    src_b_imm_i <= 1'b1;
    size_i <= mem_size_e'(size);
    if (store) begin
        mem_write_i <= 1'b1;
        rs2_i <= data;
    end else begin
        mem_read_i <= 1'b1;
        sext_i <= sext;
        wb_sel_i <= WB_MEM;
        write_rd_i <= 1'b1;
        rd_i <= 5'd6;                          // loads always land in x6.
    end
endtask

task automatic issue_branch(br_cond_e c, logic [63:0] pc, logic [63:0] imm, logic [63:0] a,
                            logic [63:0] b);
    idle();
    valid_i <= 1'b1;
    branch_i <= 1'b1;
    br_cond_i <= c;
    pc_i <= pc;
    imm_i <= imm;
    rs1_i <= a;
    rs2_i <= b;
endtask

task automatic issue_jump(logic is_jalr, logic [63:0] pc, logic [63:0] rs1,
                          logic [63:0] imm);
    idle();
    valid_i <= 1'b1;
    jal_i <= !is_jalr;
    jalr_i <= is_jalr;
    pc_i <= pc;
    rs1_i <= rs1;
    imm_i <= imm;
    wb_sel_i <= WB_LINK;
    write_rd_i <= 1'b1;
    rd_i <= 5'd1;                              // link goes to ra.
endtask

task automatic stall_for(int k);
    for (int i = 0; i < k; i++) begin
        idle();
        stall_i <= 1'b1;
        @(negedge clk);
        if (wb_en_o !== 1'b0) begin
            $display("writeback showed up while the pipeline was stalled.");
            errors++;
        end
    end
endtask

task automatic expect_wb(logic en, logic [4:0] rd, logic [63:0] data);
    @(negedge clk);                            // outputs are settled mid cycle.
    if (wb_en_o !== en) begin
        $display("[FAIL] wb_en_o expected %h got %h", en, wb_en_o);
        errors++;
    end
    if (en && wb_rd_o !== rd) begin
        $display("[FAIL] wb_rd_o expected %h got %h", rd, wb_rd_o);
        errors++;
    end
    if (en && wb_data_o !== data) begin
        $display("[FAIL] wb_data_o expected %h got %h", data, wb_data_o);
        errors++;
    end
endtask

task automatic expect_redirect(logic taken, logic [63:0] target);
    @(negedge clk);
    if (redirect_o !== taken) begin
        $display("[FAIL] redirect_o expected %h got %h", taken, redirect_o);
        errors++;
    end
    if (taken && redirect_pc_o !== target) begin
        $display("[FAIL] redirect_pc_o expected %h got %h", target, redirect_pc_o);
        errors++;
    end
endtask

task automatic test_reset();
    expect_wb(1'b0, 5'd0, 64'd0);
    @(negedge clk);
    if (redirect_o !== 1'b0) begin
        $display("[FAIL] redirect_o expected %h got %h", 1'b0, redirect_o);
        errors++;
    end
endtask

// back to back issue, each result checked two edges later.
task automatic test_alu();
    logic [63:0] exp_data [20];
    logic [4:0]  exp_rd [20];
    logic [63:0] pc, rs1, rs2, imm;
    for (int op = 0; op < 11; op++) begin
        for (int i = 0; i < 20; i++) begin
            pc  = lcg_next();
            rs1 = lcg_next();
            rs2 = lcg_next();
            imm = lcg_next();
            exp_rd[i]   = (i % 7 == 3) ? 5'd0 : 5'(i + 1);      // some go to x0.
            exp_data[i] = alu_ref(alu_op_e'(op), (i % 2 == 1) ? pc : rs1,
                                  (i % 4 >= 2) ? imm : rs2);
            issue_alu(alu_op_e'(op), i % 2 == 1, i % 4 >= 2, pc, rs1, rs2, imm, exp_rd[i]);
            if (i >= 2) begin
                expect_wb(exp_rd[i-2] != 5'd0, exp_rd[i-2], exp_data[i-2]);
            end
        end
        idle();
        expect_wb(exp_rd[18] != 5'd0, exp_rd[18], exp_data[18]);
        idle();
        expect_wb(exp_rd[19] != 5'd0, exp_rd[19], exp_data[19]);
    end
endtask

task automatic test_memory();
    logic [63:0] addr, data;
    for (int k = 0; k < 8; k++) begin
        data = lcg_next();
        store_model(MEM_BASE + 8 * k, 3, data);
        issue_mem(1'b1, 3, 1'b0, MEM_BASE + 8 * k, data);  // fill the whole window first.
    end
    idle();
    idle();
    for (int s = 0; s < 4; s++) begin
        for (int k = 0; k < 2; k++) begin
            addr = MEM_BASE + 8 * (lcg_next() % 8) + (k == 1 ? 8 - (1 << s) : 0);
            data = lcg_next();
            store_model(addr, s, data);
            issue_mem(1'b1, s, 1'b0, addr, data);
            issue_mem(1'b0, s, k == 1, addr, 64'd0);     // load straight after the store.
            idle();
            idle();
            expect_wb(1'b1, 5'd6, load_ref(addr, s, k == 1));
        end
    end
    for (int s = 0; s < 4; s++) begin
        for (int sx = 0; sx < 2; sx++) begin
            for (int k = 0; k < 2; k++) begin
                addr = MEM_BASE + 8 * (lcg_next() % 8) + (k == 1 ? 8 - (1 << s) : 0);
                issue_mem(1'b0, s, sx == 1, addr, 64'd0);
                idle();
                idle();
                expect_wb(1'b1, 5'd6, load_ref(addr, s, sx == 1));
            end
        end
    end
endtask

task automatic test_control();
    br_cond_e    conds [6];
    logic [63:0] pc, imm, a, b, rs1;
    logic        taken;
    conds = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
    for (int c = 0; c < 6; c++) begin
        for (int p = 0; p < 3; p++) begin
            a     = (p == 0) ? 64'd3 : (p == 1) ? -64'sd5 : 64'd7;
            b     = (p == 0) ? -64'sd5 : (p == 1) ? 64'd3 : 64'd7;
            taken = br_ref(conds[c], a, b);
            pc    = lcg_next() & ~64'h3;
            imm   = lcg_next() & 64'h0ffe;
            issue_branch(conds[c], pc, imm, a, b);
            issue_alu(ALU_ADD, 1'b0, 1'b1, pc, a, b, 64'd1, 5'd5);  // the wrong-path victim.
            expect_redirect(taken, pc + imm);
            idle();
            expect_wb(1'b0, 5'd0, 64'd0);
            idle();
            expect_wb(!taken, 5'd5, a + 64'd1);
        end
    end
    for (int j = 0; j < 2; j++) begin
        pc  = lcg_next() & ~64'h3;
        rs1 = lcg_next() | 64'd1;              // odd sum shows bit 0 being cleared.
        imm = lcg_next() & 64'h0ffe;
        issue_jump(j == 1, pc, rs1, imm);
        issue_mem(1'b1, 3, 1'b0, MEM_BASE, ~load_ref(MEM_BASE, 3, 1'b0));  // must not land.
        expect_redirect(1'b1, (j == 1) ? ((rs1 + imm) & ~64'd1) : pc + imm);
        idle();
        expect_wb(1'b1, 5'd1, pc + 64'd4);
        issue_mem(1'b0, 3, 1'b0, MEM_BASE, 64'd0);
        idle();
        idle();
        expect_wb(1'b1, 5'd6, load_ref(MEM_BASE, 3, 1'b0));
    end
endtask

task automatic test_stall_clear();
    logic [63:0] a, b, data;
    a = lcg_next();
    b = lcg_next();
    issue_alu(ALU_XOR, 1'b0, 1'b0, 64'd0, a, b, 64'd0, 5'd7);
    stall_for(3);
    idle();
    expect_wb(1'b0, 5'd0, 64'd0);
    idle();
    expect_wb(1'b1, 5'd7, a ^ b);              // three edges late, same value.
    data = lcg_next();
    store_model(MEM_BASE + 16, 2, data);
    issue_mem(1'b1, 2, 1'b0, MEM_BASE + 16, data);
    stall_for(2);
    issue_mem(1'b0, 2, 1'b1, MEM_BASE + 16, 64'd0);
    idle();
    idle();
    expect_wb(1'b1, 5'd6, load_ref(MEM_BASE + 16, 2, 1'b1));
    issue_jump(1'b1, 64'h200, a, 64'h20);
    bubble_i <= 1'b1;                          // present while the slot samples the issue.
    idle();
    expect_redirect(1'b0, 64'd0);
    idle();
    expect_wb(1'b0, 5'd0, 64'd0);
    issue_jump(1'b0, 64'h400, 64'd0, 64'h40);
    flush_i <= 1'b1;
    idle();
    expect_redirect(1'b0, 64'd0);
    idle();
    expect_wb(1'b0, 5'd0, 64'd0);
endtask

`endif

//--- tb/tb_ex_me.sv
`timescale 1ns/1ps

module tb_ex_me;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int          CLK_PERIOD  = 100;
    localparam logic [63:0] MEM_BASE    = 64'h100;   // all memory traffic stays in this window.
    // reset, alu, memory, control flow and stall/clear sections, in that order.
    localparam int TEST_CYCLES     = 4 + 11 * 22 + (2 + 8 + 8 * 4 + 16 * 3) + (18 * 4 + 2 * 7)
                                   + 40;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

    logic              clk;
    logic              reset_i;
    logic              valid_i;
    logic [XLEN-1:0]   pc_i;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   rs1_i;
    logic [XLEN-1:0]   rs2_i;
    alu_op_e           alu_op_i;
    logic              src_a_pc_i;
    logic              src_b_imm_i;
    logic              branch_i;
    br_cond_e          br_cond_i;
    logic              jal_i;
    logic              jalr_i;
    logic              mem_read_i;
    logic              mem_write_i;
    mem_size_e         size_i;
    logic              sext_i;
    wb_sel_e           wb_sel_i;
    logic              write_rd_i;
    logic [4:0]        rd_i;
    logic              stall_i;
    logic              bubble_i;
    logic              flush_i;
    logic              wb_en_o;
    logic [4:0]        wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;
    logic              redirect_o;
    logic [XLEN-1:0]   redirect_pc_o;

    int                errors    = 0;
    logic [63:0]       lcg_state = 64'd3849;   // fixed seed keeps every run the same.
    logic [7:0]        mem_model [DMEM_BYTES];  // byte image of what the data ram should hold.

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles.", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    ex_me_top dut0 (
        .clk (clk), .reset_i (reset_i), .valid_i (valid_i), .pc_i (pc_i), .imm_i (imm_i),
        .rs1_i (rs1_i), .rs2_i (rs2_i), .alu_op_i (alu_op_i), .src_a_pc_i (src_a_pc_i),
        .src_b_imm_i (src_b_imm_i), .branch_i (branch_i), .br_cond_i (br_cond_i),
        .jal_i (jal_i), .jalr_i (jalr_i), .mem_read_i (mem_read_i),
        .mem_write_i (mem_write_i), .size_i (size_i), .sext_i (sext_i),
        .wb_sel_i (wb_sel_i), .write_rd_i (write_rd_i), .rd_i (rd_i), .stall_i (stall_i),
        .bubble_i (bubble_i), .flush_i (flush_i), .wb_en_o (wb_en_o), .wb_rd_o (wb_rd_o),
        .wb_data_o (wb_data_o), .redirect_o (redirect_o), .redirect_pc_o (redirect_pc_o)
    );

    // 64-bit linear congruential generator, the usual knuth constants.
    function automatic logic [63:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state;
    endfunction

    // alu result as the rv64i spec defines it. Signed compares flip the sign bit.
    function automatic logic [63:0] alu_ref(alu_op_e op, logic [63:0] a, logic [63:0] b);
        logic [5:0]  sh;
        logic [63:0] flip;
        sh   = b[5:0];
        flip = 64'h8000_0000_0000_0000;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return ((a ^ flip) < (b ^ flip)) ? 64'd1 : 64'd0;
            ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[63] ? ~(~64'd0 >> sh) : 64'd0);  // sign fill.
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_LUI:  return b;
            default:  return 64'd0;
        endcase
    endfunction

    function automatic logic br_ref(br_cond_e c, logic [63:0] a, logic [63:0] b);
        logic [63:0] flip;
        flip = 64'h8000_0000_0000_0000;
        case (c)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return (a ^ flip) < (b ^ flip);
            BR_GE:   return (a ^ flip) >= (b ^ flip);
            BR_LTU:  return a < b;
            BR_GEU:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // updates the byte image for a store that is expected to land.
    task automatic store_model(logic [63:0] addr, int size, logic [63:0] data);
        for (int b = 0; b < (1 << size); b++) begin
            mem_model[addr + b] = data[8*b +: 8];
        end
    endtask

    function automatic logic [63:0] load_ref(logic [63:0] addr, int size, logic sext);
        logic [63:0] v;
        int          n;
        v = 64'd0;
        n = 1 << size;
        for (int b = 0; b < n; b++) begin
            v[8*b +: 8] = mem_model[addr + b];
        end
        if (sext && n < 8 && v[8*n-1]) begin
            v = v | (~64'd0 << (8 * n));     // copy the top loaded bit upward.
        end
        return v;
    endfunction

    `include "ex_me_tests.svh"

    initial begin
        zero_inputs();
        reset_i <= 1'b1;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        test_reset();
        test_alu();
        test_memory();
        test_control();
        test_stall_clear();
        idle();
        $display("checks finished with %0d errors.", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
